//--- vlog.f
hdl/uart_cmd_pkg.sv
hdl/cmd_fifo.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_sequencer.sv
hdl/uart_cmd_bridge.sv
tb/tb_clk_gen.sv
tb/tb_uart_cmd_bridge.sv

//--- Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - files:
      - hdl/uart_cmd_pkg.sv
      - hdl/cmd_fifo.sv
      - hdl/uart_tx_frame.sv
      - hdl/uart_rx_frame.sv
      - hdl/uart_cmd_sequencer.sv
      - hdl/uart_cmd_bridge.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_uart_cmd_bridge.sv

//--- tb/tb_uart_cmd_bridge.sv
module tb_uart_cmd_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS      = 200;
  localparam int CLK_PERIOD_NS = 100;
  localparam int BAUD_DIV      = uart_cmd_pkg::BAUD_DIV;
  localparam int TRANS_CYCLES  = 2 * 11 * BAUD_DIV + uart_cmd_pkg::GAP_CYCLES +
                                 (uart_cmd_pkg::RX_TIMEOUT_BITS + 8) * BAUD_DIV;
  localparam int WATCHDOG_NS   = 2 * NUM_CMDS * TRANS_CYCLES * CLK_PERIOD_NS;
  localparam logic [31:0] SEED = 32'h8f8d943a;

  logic                                clk;
  logic                                rst_n;
  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in;
  logic                                cmd_vld;
  logic                                cmd_rdy;
  logic                                rx;
  logic                                tx;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data;
  logic                                read_vld;
  logic                                read_err;

  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_q [$];  // Accepted commands in order.
  logic [8:0]                          exp_q [$];  // Expected {read_err, read_data}.
  logic [7:0]                          mem [128];
  logic [31:0]                         stim_lfsr;
  logic [31:0]                         dev_lfsr;
  int accepted     = 0;
  int started      = 0;
  int trans_done   = 0;
  int reads_issued = 0;
  int reads_done   = 0;

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge dut_i (
    .clk(clk), .rst_n(rst_n),
    .cmd_in(cmd_in), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy),
    .rx(rx), .tx(tx),
    .read_data(read_data), .read_vld(read_vld), .read_err(read_err)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32, 22, 2, 1.
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_failure(input string msg);
    $display("At %0d ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Counts high samples on tx until a start bit shows up.
  task automatic wait_frame_start(output int idle);
    idle = 0;
    @(negedge clk);
    while (tx !== 1'b0)
    begin
      idle++;
      @(negedge clk);
    end
  endtask

  task automatic read_frame(output logic [7:0] value);
    int i;
    repeat (uart_cmd_pkg::BAUD_HALF) @(negedge clk);
    if (tx !== 1'b0)
      stop_on_failure("start bit on tx did not stay low until mid-bit");
    for (i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      value[i] = tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    compare_value("tx parity bit", ^value, tx);
    repeat (BAUD_DIV) @(negedge clk);
    if (tx !== 1'b1)
      stop_on_failure("stop bit on tx is not high");
  endtask

  task automatic send_reply(input logic [7:0] value, input logic bad_parity);
    int i;
    rx = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    for (i = 0; i < 8; i++)
    begin
      rx = value[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rx = (^value) ^ bad_parity;
    repeat (BAUD_DIV) @(negedge clk);
    rx = 1'b1;  // Stop bit, and the line idles high from here on.
  endtask

  // Remote device: decodes each transaction on tx and answers reads on rx.
  initial
  begin
    logic [uart_cmd_pkg::CMD_WIDTH-1:0] cmd;
    logic [7:0]  hdr;
    logic [7:0]  data;
    logic [31:0] r;
    int          idle;
    int          delay;
    logic        bad;
    rx = 1'b1;
    for (int a = 0; a < 128; a++)
      mem[a] = 8'h00;
    @(posedge rst_n);
    forever
    begin
      wait_frame_start(idle);
      if (cmd_q.size() == 0)
        stop_on_failure("frame on tx with no accepted command left");
      cmd = cmd_q.pop_front();
      started++;
      read_frame(hdr);
      compare_value("tx address byte", {cmd[15], cmd[14:8]}, hdr);
      if (uart_cmd_pkg::cmd_op_e'(cmd[15]) == uart_cmd_pkg::OP_WRITE)
      begin
        wait_frame_start(idle);
        // Idle count starts at mid-stop, so half a bit is already in it.
        if (idle + 1 - uart_cmd_pkg::BAUD_HALF < uart_cmd_pkg::GAP_CYCLES)
          stop_on_failure("tx idle gap between write bytes is too short");
        read_frame(data);
        compare_value("tx data byte", cmd[7:0], data);
        mem[hdr[6:0]] = data;
      end
      else
      begin
        take_bits(dev_lfsr, 3, r);
        delay = r + 1;
        take_bits(dev_lfsr, 8, r);
        reads_issued++;
        if (r < 13)
          exp_q.push_back({1'b1, 8'h00});  // No reply, the bridge must time out.
        else
        begin
          bad = (r < 39);
          exp_q.push_back(bad ? {1'b1, 8'h00} : {1'b0, mem[hdr[6:0]]});
          repeat (delay * BAUD_DIV) @(negedge clk);
          send_reply(mem[hdr[6:0]], bad);
        end
      end
      trans_done++;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_vld === 1'b1)
    begin
      if (exp_q.size() == 0)
        stop_on_failure("read_vld pulsed with no read outstanding");
      else
      begin
        compare_value("read_err", exp_q[0][8], read_err);
        compare_value("read_data", exp_q[0][7:0], read_data);
        void'(exp_q.pop_front());
        reads_done++;
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout at %0d ns: the transactions did not all complete", $time);
    $display("TEST FAILED");
    $fatal(1);
  end

  initial
  begin
    logic [31:0] r;
    logic        wr;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    stim_lfsr = SEED;
    take_bits(stim_lfsr, 32, dev_lfsr);
    @(posedge rst_n);
    @(negedge clk);
    compare_value("tx", 1, tx);
    compare_value("read_vld", 0, read_vld);
    compare_value("read_err", 0, read_err);
    compare_value("cmd_rdy", 1, cmd_rdy);

    for (int n = 0; n < NUM_CMDS; n++)
    begin
      take_bits(stim_lfsr, 1, r);
      wr = r[0];
      take_bits(stim_lfsr, 3, r);
      cmd_in[15]   = wr;
      cmd_in[14:8] = 7'h20 + r[2:0];  // Eight addresses, so reads hit earlier writes.
      take_bits(stim_lfsr, 8, r);
      cmd_in[7:0]  = r[7:0];
      cmd_vld      = 1'b1;
      while (cmd_rdy !== 1'b1)
      begin
        // The FIFO holds at most as many entries as commands not yet on the line.
        if (accepted - started < uart_cmd_pkg::CMD_FIFO_DEPTH)
          compare_value("cmd_rdy", 1, cmd_rdy);
        @(negedge clk);
      end
      cmd_q.push_back(cmd_in);
      accepted++;
      @(negedge clk);
      take_bits(stim_lfsr, 2, r);
      if (r == 0)
      begin
        cmd_vld = 1'b0;
        take_bits(stim_lfsr, 8, r);
        repeat (r) @(negedge clk);
      end
    end
    cmd_vld = 1'b0;

    // Once every accepted command has started on tx, the line gets one more
    // transaction time to finish and to show any frame that should not be there.
    while (cmd_q.size() != 0)
      @(negedge clk);
    repeat (TRANS_CYCLES) @(negedge clk);
    compare_value("tx", 1, tx);
    compare_value("transactions", accepted, trans_done);
    compare_value("completed reads", reads_issued, reads_done);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;  // Released on a falling edge after three full cycles.
  end

  always #50 clk = ~clk;

endmodule

//--- hdl/uart_cmd_bridge.sv
module uart_cmd_bridge (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  input  logic                                rx,
  output logic                                tx,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                                read_vld,
  output logic                                read_err
);

  logic                                fifo_vld;
  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  fifo_data;
  logic                                fifo_pop;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte;
  logic                                tx_start;
  logic                                tx_done;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_byte;
  logic                                rx_vld;
  logic                                rx_err;

  cmd_fifo fifo_i (
    .clk(clk), .rst_n(rst_n),
    .in_vld(cmd_vld), .in_data(cmd_in), .in_rdy(cmd_rdy),
    .out_vld(fifo_vld), .out_data(fifo_data), .out_pop(fifo_pop)
  );

  uart_cmd_sequencer seq_i (
    .clk(clk), .rst_n(rst_n),
    .cmd_vld(fifo_vld), .cmd_data(fifo_data), .cmd_pop(fifo_pop),
    .tx_byte(tx_byte), .tx_start(tx_start), .tx_done(tx_done),
    .rx_byte(rx_byte), .rx_vld(rx_vld), .rx_err(rx_err),
    .read_data(read_data), .read_vld(read_vld), .read_err(read_err)
  );

  uart_tx_frame tx_i (
    .clk(clk), .rst_n(rst_n),
    .tx_byte(tx_byte), .tx_start(tx_start), .tx_done(tx_done), .tx(tx)
  );

  uart_rx_frame rx_i (
    .clk(clk), .rst_n(rst_n),
    .rx(rx), .rx_byte(rx_byte), .rx_vld(rx_vld), .rx_err(rx_err)
  );

endmodule

//--- hdl/uart_cmd_sequencer.sv
module uart_cmd_sequencer (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cmd_vld,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_data,
  output logic                                cmd_pop,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte,
  output logic                                tx_start,
  input  logic                                tx_done,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_byte,
  input  logic                                rx_vld,
  input  logic                                rx_err,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                                read_vld,
  output logic                                read_err
);

  uart_cmd_pkg::seq_state_e              state;
  uart_cmd_pkg::cmd_op_e                 op;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]   wr_data;
  logic [uart_cmd_pkg::WAIT_CNT_W-1:0]   wait_cnt;  // Gap counter on writes, timeout on reads.
  logic                                  take_cmd;
  logic                                  gap_done;
  logic                                  reply;
  logic                                  timed_out;

  assign take_cmd  = (state == uart_cmd_pkg::SQ_IDLE) && cmd_vld;
  assign cmd_pop   = take_cmd;
  // Fires two clocks early so the data start bit follows exactly GAP_CYCLES idle clocks.
  assign gap_done  = (state == uart_cmd_pkg::SQ_GAP) &&
                     (wait_cnt == uart_cmd_pkg::WAIT_CNT_W'(uart_cmd_pkg::GAP_CYCLES - 2));
  assign reply     = (state == uart_cmd_pkg::SQ_WAIT_REPLY) && rx_vld;
  assign timed_out = (state == uart_cmd_pkg::SQ_WAIT_REPLY) && !rx_vld &&
                     (wait_cnt == uart_cmd_pkg::WAIT_CNT_W'(uart_cmd_pkg::TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (take_cmd)
    begin
      tx_byte <= {cmd_data[uart_cmd_pkg::CMD_WRITE_BIT],
                  cmd_data[uart_cmd_pkg::CMD_ADDR_LSB +: uart_cmd_pkg::ADDR_WIDTH]};
      op      <= uart_cmd_pkg::cmd_op_e'(cmd_data[uart_cmd_pkg::CMD_WRITE_BIT]);
      wr_data <= cmd_data[uart_cmd_pkg::BYTE_WIDTH-1:0];
    end
    else if (gap_done)
      tx_byte <= wr_data;
    if (reply)
      read_data <= rx_err ? '0 : rx_byte;
    else if (timed_out)
      read_data <= '0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::SQ_IDLE;
      wait_cnt <= '0;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= take_cmd || gap_done;
      read_vld <= reply || timed_out;
      read_err <= (reply && rx_err) || timed_out;
      wait_cnt <= '0;
      case (state)
        uart_cmd_pkg::SQ_IDLE:
          if (take_cmd)
            state <= uart_cmd_pkg::SQ_ADDR;
        uart_cmd_pkg::SQ_ADDR:
          if (tx_done)
            state <= (op == uart_cmd_pkg::OP_WRITE) ? uart_cmd_pkg::SQ_GAP :
                                                      uart_cmd_pkg::SQ_WAIT_REPLY;
        uart_cmd_pkg::SQ_GAP:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (gap_done)
            state <= uart_cmd_pkg::SQ_DATA;
        end
        uart_cmd_pkg::SQ_DATA:
          if (tx_done)
            state <= uart_cmd_pkg::SQ_IDLE;
        uart_cmd_pkg::SQ_WAIT_REPLY:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (reply || timed_out)
            state <= uart_cmd_pkg::SQ_REPORT;
        end
        default: state <= uart_cmd_pkg::SQ_IDLE;  // read_vld is high in SQ_REPORT.
      endcase
    end
  end

endmodule

//--- hdl/uart_rx_frame.sv
module uart_rx_frame (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rx,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_byte,
  output logic                                rx_vld,
  output logic                                rx_err
);

  uart_cmd_pkg::frame_state_e            state;
  logic [uart_cmd_pkg::BAUD_CNT_W-1:0]   baud_cnt;
  logic [uart_cmd_pkg::BIT_IDX_W-1:0]    bit_idx;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]   shift;
  logic                                  par_err;
  logic                                  rx_meta;
  logic                                  rx_sync;
  logic                                  rx_prev;
  logic                                  start_edge;
  logic                                  mid_start;
  logic                                  sample;

  assign start_edge = rx_prev && !rx_sync;
  assign mid_start  = (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_HALF - 1));
  // After the start bit the counter is realigned, so a full bit period lands mid-bit.
  assign sample     = (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == uart_cmd_pkg::FR_DATA && sample)
      shift <= {rx_sync, shift[uart_cmd_pkg::BYTE_WIDTH-1:1]};  // LSB arrives first.
    if (state == uart_cmd_pkg::FR_PARITY && sample)
      par_err <= ^{shift, rx_sync};
    if (state == uart_cmd_pkg::FR_STOP && sample)
    begin
      rx_byte <= shift;
      rx_err  <= par_err || !rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::FR_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_vld   <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      case (state)
        uart_cmd_pkg::FR_IDLE:
        begin
          baud_cnt <= '0;
          if (start_edge)
            state <= uart_cmd_pkg::FR_START;
        end
        uart_cmd_pkg::FR_START:
        begin
          baud_cnt <= baud_cnt + 1'b1;
          if (mid_start)
          begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            // A line that is high again by mid-bit was only a glitch.
            state    <= rx_sync ? uart_cmd_pkg::FR_IDLE : uart_cmd_pkg::FR_DATA;
          end
        end
        default:
        begin
          baud_cnt <= sample ? '0 : baud_cnt + 1'b1;
          if (sample)
          begin
            if (state == uart_cmd_pkg::FR_DATA)
            begin
              bit_idx <= bit_idx + 1'b1;
              if (bit_idx == uart_cmd_pkg::BIT_IDX_W'(uart_cmd_pkg::BYTE_WIDTH - 1))
                state <= uart_cmd_pkg::FR_PARITY;
            end
            else if (state == uart_cmd_pkg::FR_PARITY)
              state <= uart_cmd_pkg::FR_STOP;
            else
            begin
              state  <= uart_cmd_pkg::FR_IDLE;
              rx_vld <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- hdl/uart_tx_frame.sv
module uart_tx_frame (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte,
  input  logic                                tx_start,
  output logic                                tx_done,
  output logic                                tx
);

  uart_cmd_pkg::frame_state_e            state;
  logic [uart_cmd_pkg::BAUD_CNT_W-1:0]   baud_cnt;
  logic [uart_cmd_pkg::BIT_IDX_W-1:0]    bit_idx;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]   shift;
  logic                                  parity;
  logic                                  bit_end;
  logic                                  shift_en;

  assign bit_end  = (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_DIV - 1));
  assign tx_done  = (state == uart_cmd_pkg::FR_STOP) && bit_end;
  assign shift_en = bit_end && ((state == uart_cmd_pkg::FR_START) ||
                                (state == uart_cmd_pkg::FR_DATA));

  always_ff @(posedge clk)
  begin
    if (tx_start)
    begin
      shift  <= tx_byte;
      parity <= ^tx_byte;  // Even parity over the data byte.
    end
    else if (shift_en)
      shift <= shift >> 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::FR_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (tx_start)
    begin
      state    <= uart_cmd_pkg::FR_START;
      baud_cnt <= '0;
      tx       <= 1'b0;  // Start bit.
    end
    else if (state != uart_cmd_pkg::FR_IDLE)
    begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      if (bit_end)
      begin
        case (state)
          uart_cmd_pkg::FR_START:
          begin
            state   <= uart_cmd_pkg::FR_DATA;
            bit_idx <= '0;
            tx      <= shift[0];
          end
          uart_cmd_pkg::FR_DATA:
          begin
            if (bit_idx == uart_cmd_pkg::BIT_IDX_W'(uart_cmd_pkg::BYTE_WIDTH - 1))
            begin
              state <= uart_cmd_pkg::FR_PARITY;
              tx    <= parity;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[0];
            end
          end
          uart_cmd_pkg::FR_PARITY:
          begin
            state <= uart_cmd_pkg::FR_STOP;
            tx    <= 1'b1;
          end
          default: state <= uart_cmd_pkg::FR_IDLE;  // End of stop bit, line stays high.
        endcase
      end
    end
  end

endmodule

//--- hdl/cmd_fifo.sv
module cmd_fifo (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_vld,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0] in_data,
  output logic                               in_rdy,
  output logic                               out_vld,
  output logic [uart_cmd_pkg::CMD_WIDTH-1:0] out_data,
  input  logic                               out_pop
);

  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  mem [uart_cmd_pkg::CMD_FIFO_DEPTH];
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [uart_cmd_pkg::FIFO_CNT_W-1:0] count;
  logic                                push;
  logic                                pop;

  assign in_rdy   = (count != uart_cmd_pkg::FIFO_CNT_W'(uart_cmd_pkg::CMD_FIFO_DEPTH));
  assign out_vld  = (count != '0);
  assign out_data = mem[rd_ptr];  // Head entry is always presented.
  assign push     = in_vld && in_rdy;
  assign pop      = out_pop && out_vld;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == uart_cmd_pkg::FIFO_PTR_W'(uart_cmd_pkg::CMD_FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == uart_cmd_pkg::FIFO_PTR_W'(uart_cmd_pkg::CMD_FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push with pop leaves the occupancy as is.
      endcase
    end
  end

endmodule

//--- hdl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int CMD_WIDTH       = 16;
  localparam int ADDR_WIDTH      = 7;
  localparam int BYTE_WIDTH      = 8;
  localparam int BAUD_DIV        = 16;  // Clocks per bit. 434 on a real board.
  localparam int GAP_CYCLES      = 16;
  localparam int RX_TIMEOUT_BITS = 24;
  localparam int CMD_FIFO_DEPTH  = 4;

  // Command field positions.
  localparam int CMD_WRITE_BIT = 15;
  localparam int CMD_ADDR_LSB  = 8;

  localparam int BAUD_HALF      = BAUD_DIV / 2;
  localparam int BAUD_CNT_W     = $clog2(BAUD_DIV);
  localparam int BIT_IDX_W      = $clog2(BYTE_WIDTH);
  localparam int TIMEOUT_CYCLES = RX_TIMEOUT_BITS * BAUD_DIV;
  localparam int WAIT_CNT_W     = $clog2(TIMEOUT_CYCLES);
  localparam int FIFO_PTR_W     = $clog2(CMD_FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(CMD_FIFO_DEPTH + 1);

  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [2:0] {
    FR_IDLE, FR_START, FR_DATA, FR_PARITY, FR_STOP
  } frame_state_e;

  typedef enum logic [2:0] {
    SQ_IDLE, SQ_ADDR, SQ_GAP, SQ_DATA, SQ_WAIT_REPLY, SQ_REPORT
  } seq_state_e;

endpackage
